// ==== adc_sweep_macros.svh ====
// timing, segment length and width constants for the adc sweep sequencer
`ifndef ADC_SWEEP_MACROS_SVH
`define ADC_SWEEP_MACROS_SVH

// adc clock divider
`define ADC_CLK_HALF 10        // enabled clk cycles per adc_clk half period

// segment lengths in enabled clk cycles, 40 per repetition
`define GND_CYCLES 8
`define REL_CYCLES 2
`define EXC_CYCLES 24
`define REST_CYCLES 6

// capture offset inside excite for phase 0, one cycle earlier per phase
`define SAMPLE_DELAY_BASE 20

// sweep shape
`define N_PHASES 5
`define N_REPEATS 4
`define N_CHANNELS 4

// data widths
`define SAMPLE_W 14
`define MEAN_W 16

`endif

// ==== adc_sweep_pkg.sv ====
// adc_sweep_pkg: vector typedefs and the segment enum of the sweep sequencer
`default_nettype none

`include "adc_sweep_macros.svh"

package adc_sweep_pkg;

	typedef logic [`SAMPLE_W-1:0] sample_t;     // one adc code
	typedef logic [`MEAN_W-1:0] mean_t;         // running sum or mean of four codes

	typedef logic [2:0] phase_t;                // sub-sampling phase 0..4
	typedef logic [1:0] repeat_t;               // repetition within a phase
	typedef logic [4:0] seg_count_t;            // cycle index inside a segment

	typedef logic [`N_CHANNELS-1:0] chan_mask_t; // one bit per trigger channel
	typedef logic [3:0] chan_sel_t;             // channel selector, >= N_CHANNELS is off

	// segments of one repetition, DONE parks the sequencer after phase 4
	typedef enum logic [2:0] {
		SEG_GROUND  = 3'd0,
		SEG_RELEASE = 3'd1,
		SEG_EXCITE  = 3'd2,
		SEG_REST    = 3'd3,
		SEG_DONE    = 3'd4
	} segment_e;

endpackage

`default_nettype wire

// ==== adc_clock_div.sv ====
// adc_clock_div: enabled divider producing adc_clk from clk
`default_nettype none

`include "adc_sweep_macros.svh"

module adc_clock_div (
	input  wire  clk,
	input  wire  rst,
	input  wire  we,        // run enable, divider freezes while low
	output logic adc_clk
);

	typedef logic [$clog2(`ADC_CLK_HALF)-1:0] div_count_t;

	div_count_t div_count;  // enabled cycles into the current half period
	logic       half_wrap;

	assign half_wrap = (div_count == div_count_t'(`ADC_CLK_HALF - 1));

	// half-period counter
	always_ff @(posedge clk) begin
		if (rst) begin
			div_count <= '0;
		end else if (we) begin
			if (half_wrap)
				div_count <= '0;
			else
				div_count <= div_count + 1'b1;
		end
	end

	// toggle on every wrap, period is 2 * ADC_CLK_HALF enabled cycles
	always_ff @(posedge clk) begin
		if (rst) begin
			adc_clk <= 1'b0;
		end else if (we && half_wrap) begin
			adc_clk <= ~adc_clk;
		end
	end

endmodule

`default_nettype wire

// ==== sweep_sequencer.sv ====
// sweep_sequencer: phase, repeat and segment FSM with segment cycle counter and sample strobe
`default_nettype none

`include "adc_sweep_macros.svh"

module sweep_sequencer (
	input  wire                       clk,
	input  wire                       rst,
	input  wire                       we,
	input  wire                       one_shot,      // hold result in DONE while high
	output adc_sweep_pkg::segment_e   segment,
	output adc_sweep_pkg::phase_t     phase,
	output logic                      sample_strobe,
	output logic                      sweep_start,
	output logic                      sweep_done
);

	import adc_sweep_pkg::*;

	repeat_t    rep;         // repetition index inside the phase
	seg_count_t seg_count;   // cycles spent in the current segment
	logic       seg_last;    // current cycle is the segment's last one
	logic       rep_last;
	logic       phase_last;
	seg_count_t capture_at;  // excite cycle that takes the sample

	assign rep_last   = (rep == repeat_t'(`N_REPEATS - 1));
	assign phase_last = (phase == phase_t'(`N_PHASES - 1));

	// later phases sample one cycle earlier
	assign capture_at = seg_count_t'(`SAMPLE_DELAY_BASE) - seg_count_t'(phase);

	// segment length decode
	always_comb begin
		case (segment)
			SEG_GROUND:  seg_last = (seg_count == seg_count_t'(`GND_CYCLES - 1));
			SEG_RELEASE: seg_last = (seg_count == seg_count_t'(`REL_CYCLES - 1));
			SEG_EXCITE:  seg_last = (seg_count == seg_count_t'(`EXC_CYCLES - 1));
			SEG_REST:    seg_last = (seg_count == seg_count_t'(`REST_CYCLES - 1));
			default:     seg_last = 1'b1;  // DONE keeps the counter at zero
		endcase
	end

	// segment cycle counter
	always_ff @(posedge clk) begin
		if (rst) begin
			seg_count <= '0;
		end else if (we) begin
			if (seg_last)
				seg_count <= '0;
			else
				seg_count <= seg_count + 1'b1;
		end
	end

	// segment, repetition and phase advance
	always_ff @(posedge clk) begin
		if (rst) begin
			segment <= SEG_GROUND;
			rep     <= '0;
			phase   <= '0;
		end else if (we) begin
			case (segment)
				SEG_GROUND: begin
					if (seg_last)
						segment <= SEG_RELEASE;
				end
				SEG_RELEASE: begin
					if (seg_last)
						segment <= SEG_EXCITE;
				end
				SEG_EXCITE: begin
					if (seg_last)
						segment <= SEG_REST;
				end
				SEG_REST: begin
					if (seg_last) begin
						if (!rep_last) begin
							rep     <= rep + 1'b1;
							segment <= SEG_GROUND;
						end else if (!phase_last) begin
							rep     <= '0;
							phase   <= phase + 1'b1;
							segment <= SEG_GROUND;
						end else begin
							rep     <= '0;
							phase   <= '0;       // ready for the next sweep
							segment <= SEG_DONE;
						end
					end
				end
				SEG_DONE: begin
					if (!one_shot)
						segment <= SEG_GROUND;  // restart after one DONE cycle
				end
				default: begin
					segment <= SEG_GROUND;
				end
			endcase
		end
	end

	assign sample_strobe = (segment == SEG_EXCITE) && (seg_count == capture_at);

	// first ground cycle of phase 0
	assign sweep_start = (segment == SEG_GROUND) && (phase == '0) && (rep == '0)
		&& (seg_count == '0);

	// last rest cycle of the final repetition of the final phase
	assign sweep_done = (segment == SEG_REST) && seg_last && rep_last && phase_last;

	// capture lands inside excite and never on its last cycle
	a_strobe_in_excite: assert property (@(posedge clk) disable iff (rst)
		(sample_strobe && we) |=> (segment == SEG_EXCITE) && !sample_strobe);

	a_phase_range: assert property (@(posedge clk) disable iff (rst)
		phase <= phase_t'(`N_PHASES - 1));

endmodule

`default_nettype wire

// ==== trigger_driver.sv ====
// trigger_driver: channel decode and registered trigger vdd/gnd outputs
`default_nettype none

`include "adc_sweep_macros.svh"

module trigger_driver (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         we,
	input  adc_sweep_pkg::chan_sel_t    trigger_sel,
	input  adc_sweep_pkg::segment_e     segment,
	output adc_sweep_pkg::chan_mask_t   trigger_vdd,
	output adc_sweep_pkg::chan_mask_t   trigger_gnd
);

	import adc_sweep_pkg::*;

	chan_mask_t chan_mask;  // one-hot selected channel

	// out of range selector drives nothing
	always_comb begin
		if (trigger_sel < chan_sel_t'(`N_CHANNELS))
			chan_mask = chan_mask_t'(1'b1) << trigger_sel;
		else
			chan_mask = '0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			trigger_vdd <= '0;
			trigger_gnd <= '0;
		end else if (we) begin
			case (segment)
				SEG_GROUND: begin
					trigger_vdd <= '0;
					trigger_gnd <= chan_mask;   // discharge the sensor
				end
				SEG_EXCITE: begin
					trigger_vdd <= chan_mask;   // excite the sensor
					trigger_gnd <= '0;
				end
				default: begin
					trigger_vdd <= '0;
					trigger_gnd <= '0;
				end
			endcase
		end
	end

	a_vdd_gnd_exclusive: assert property (@(posedge clk) disable iff (rst)
		!((|trigger_vdd) && (|trigger_gnd)));

	a_single_channel: assert property (@(posedge clk) disable iff (rst)
		$onehot0(trigger_vdd) && $onehot0(trigger_gnd));

endmodule

`default_nettype wire

// ==== sample_accumulator.sv ====
// sample_accumulator: per-phase sample sums, mean registers and end flag
`default_nettype none

`include "adc_sweep_macros.svh"

module sample_accumulator (
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      we,
	input  adc_sweep_pkg::sample_t   bn,
	input  adc_sweep_pkg::phase_t    phase,
	input  wire                      sample_strobe,
	input  wire                      sweep_start,
	input  wire                      sweep_done,
	output adc_sweep_pkg::mean_t     mean_s1,
	output adc_sweep_pkg::mean_t     mean_s2,
	output adc_sweep_pkg::mean_t     mean_s3,
	output adc_sweep_pkg::mean_t     mean_s4,
	output adc_sweep_pkg::mean_t     mean_s5,
	output logic                     end_flag
);

	import adc_sweep_pkg::*;

	mean_t sum [`N_PHASES];  // four codes per phase, 16 bits never overflow

	// running sums, cleared at the start of each sweep
	always_ff @(posedge clk) begin
		if (we) begin
			if (sweep_start) begin
				for (int i = 0; i < `N_PHASES; i++)
					sum[i] <= '0;
			end else if (sample_strobe) begin
				sum[phase] <= sum[phase] + mean_t'(bn);
			end
		end
	end

	// means of the finished sweep, divide by N_REPEATS
	always_ff @(posedge clk) begin
		if (rst) begin
			mean_s1 <= '0;
			mean_s2 <= '0;
			mean_s3 <= '0;
			mean_s4 <= '0;
			mean_s5 <= '0;
		end else if (we && sweep_done) begin
			mean_s1 <= sum[0] >> 2;
			mean_s2 <= sum[1] >> 2;
			mean_s3 <= sum[2] >> 2;
			mean_s4 <= sum[3] >> 2;
			mean_s5 <= sum[4] >> 2;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			end_flag <= 1'b0;
		end else if (we) begin
			if (sweep_done)
				end_flag <= 1'b1;
			else if (sweep_start)
				end_flag <= 1'b0;  // cleared when the next sweep begins
		end
	end

	// sequencer never captures on the cycle that clears the sums
	a_no_strobe_on_start: assert property (@(posedge clk) disable iff (rst)
		!(sample_strobe && sweep_start));

endmodule

`default_nettype wire

// ==== adc_sweep_top.sv ====
// adc_sweep_top: clock divider, sweep sequencer, trigger driver and sample accumulator
`default_nettype none

module adc_sweep_top (
	input  wire                         clk,
	input  wire                         rst,
	input  wire                         we,
	input  adc_sweep_pkg::sample_t      bn,
	input  adc_sweep_pkg::chan_sel_t    trigger_sel,
	input  wire                         one_shot,
	output logic                        adc_clk,
	output logic                        end_flag,
	output adc_sweep_pkg::chan_mask_t   trigger_vdd,
	output adc_sweep_pkg::chan_mask_t   trigger_gnd,
	output adc_sweep_pkg::mean_t        mean_s1,
	output adc_sweep_pkg::mean_t        mean_s2,
	output adc_sweep_pkg::mean_t        mean_s3,
	output adc_sweep_pkg::mean_t        mean_s4,
	output adc_sweep_pkg::mean_t        mean_s5
);

	import adc_sweep_pkg::*;

	segment_e segment;
	phase_t   phase;
	logic     sample_strobe;
	logic     sweep_start;
	logic     sweep_done;

	adc_clock_div i_adc_clock_div (
		.clk     (clk),
		.rst     (rst),
		.we      (we),
		.adc_clk (adc_clk)
	);

	sweep_sequencer i_sweep_sequencer (
		.clk           (clk),
		.rst           (rst),
		.we            (we),
		.one_shot      (one_shot),
		.segment       (segment),
		.phase         (phase),
		.sample_strobe (sample_strobe),
		.sweep_start   (sweep_start),
		.sweep_done    (sweep_done)
	);

	trigger_driver i_trigger_driver (
		.clk         (clk),
		.rst         (rst),
		.we          (we),
		.trigger_sel (trigger_sel),
		.segment     (segment),
		.trigger_vdd (trigger_vdd),
		.trigger_gnd (trigger_gnd)
	);

	sample_accumulator i_sample_accumulator (
		.clk           (clk),
		.rst           (rst),
		.we            (we),
		.bn            (bn),
		.phase         (phase),
		.sample_strobe (sample_strobe),
		.sweep_start   (sweep_start),
		.sweep_done    (sweep_done),
		.mean_s1       (mean_s1),
		.mean_s2       (mean_s2),
		.mean_s3       (mean_s3),
		.mean_s4       (mean_s4),
		.mean_s5       (mean_s5),
		.end_flag      (end_flag)
	);

endmodule

`default_nettype wire

// ==== tb_adc_sweep.sv ====
// tb_adc_sweep: clock, reset, stimulus, reference model and checks for adc_sweep_top
`default_nettype none

`include "adc_sweep_macros.svh"

module tb_adc_sweep;

	localparam int REP_CYCLES = `GND_CYCLES + `REL_CYCLES + `EXC_CYCLES + `REST_CYCLES;
	localparam int SWEEP_CYCLES = `N_PHASES * `N_REPEATS * REP_CYCLES;
	localparam int SWEEP_PULSES = `N_PHASES * `N_REPEATS;
	localparam int TIMEOUT_CYCLES = 5 * SWEEP_CYCLES;  // three sweeps plus hold, freeze, margin

	logic                   clk = 1'b0;
	logic                   rst;
	logic                   we;
	logic [`SAMPLE_W-1:0]   bn = '0;
	logic [3:0]             trigger_sel;
	logic                   one_shot;
	logic                   adc_clk;
	logic                   end_flag;
	logic [`N_CHANNELS-1:0] trigger_vdd;
	logic [`N_CHANNELS-1:0] trigger_gnd;
	logic [`MEAN_W-1:0]     mean_s1;
	logic [`MEAN_W-1:0]     mean_s2;
	logic [`MEAN_W-1:0]     mean_s3;
	logic [`MEAN_W-1:0]     mean_s4;
	logic [`MEAN_W-1:0]     mean_s5;
	logic [`MEAN_W-1:0]     got_means [`N_PHASES];
	logic [`MEAN_W-1:0]     held [`N_PHASES];

	integer seed = 32'h6449590b;
	int     err_count = 0;
	int     test_count = 0;
	int     test_base = 0;
	int     cycle_count = 0;
	int     en_edges = 0;       // enabled clk edges since reset
	int     gnd_len = 0;
	int     vdd_len = 0;

	// reference model, updated on falling edges only
	int          sums [`N_PHASES] = '{default: 0};
	int          rises = 0;     // gnd pulses seen in the current sweep
	int          sweep_ref = 0; // en_edges at the start of the current sweep
	logic        prev_gnd = 1'b0;
	logic        prev_end = 1'b0;
	logic        new_sweep;
	logic        gnd_rise;
	logic        exp_clk;
	logic [31:0] draw;
	logic        frozen_clk;
	logic [`N_CHANNELS-1:0] frozen_vdd;
	logic [`N_CHANNELS-1:0] frozen_gnd;

	assign got_means[0] = mean_s1;
	assign got_means[1] = mean_s2;
	assign got_means[2] = mean_s3;
	assign got_means[3] = mean_s4;
	assign got_means[4] = mean_s5;

	adc_sweep_top i_adc_sweep_top (
		.clk         (clk),
		.rst         (rst),
		.we          (we),
		.bn          (bn),
		.trigger_sel (trigger_sel),
		.one_shot    (one_shot),
		.adc_clk     (adc_clk),
		.end_flag    (end_flag),
		.trigger_vdd (trigger_vdd),
		.trigger_gnd (trigger_gnd),
		.mean_s1     (mean_s1),
		.mean_s2     (mean_s2),
		.mean_s3     (mean_s3),
		.mean_s4     (mean_s4),
		.mean_s5     (mean_s5)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	// one-hot channel of a selector, nothing above the last channel
	function automatic logic [`N_CHANNELS-1:0] sel_mask(input logic [3:0] sel);
		logic [`N_CHANNELS-1:0] m;
		m = '0;
		if (int'(sel) < `N_CHANNELS)
			m[sel[1:0]] = 1'b1;
		return m;
	endfunction

	task automatic report_error(input string msg);
		err_count++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic report_mismatch(input string name, input int got, input int exp);
		err_count++;
		$display("Mismatch at %0t: %s got %0d, expected %0d", $time, name, got, exp);
	endtask

	task automatic finish_test(input string name);
		test_count++;
		if (err_count == test_base)
			$display("test %0d %s: ok", test_count, name);
		else
			$display("test %0d %s: %0d errors", test_count, name, err_count - test_base);
		test_base = err_count;
	endtask

	task automatic check_idle_outputs();
		assert (adc_clk == 1'b0) else report_mismatch("adc_clk", int'(adc_clk), 0);
		assert (trigger_vdd == '0) else report_mismatch("trigger_vdd", int'(trigger_vdd), 0);
		assert (trigger_gnd == '0) else report_mismatch("trigger_gnd", int'(trigger_gnd), 0);
		assert (end_flag == 1'b0) else report_mismatch("end_flag", int'(end_flag), 0);
		for (int p = 0; p < `N_PHASES; p++) begin
			assert (got_means[p] == '0)
				else report_mismatch($sformatf("mean_s%0d", p + 1), int'(got_means[p]), 0);
		end
	endtask

	task automatic wait_end_flag(input logic level, input string what);
		int waited;
		waited = 0;
		while (end_flag !== level && waited < SWEEP_CYCLES + REP_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		assert (end_flag === level) else report_error(what);
	endtask

	task automatic wait_vdd_pulse();
		int waited;
		waited = 0;
		while (trigger_vdd == '0 && waited < REP_CYCLES) begin
			@(negedge clk);
			waited++;
		end
		assert (trigger_vdd != '0) else report_error("no trigger_vdd pulse before the freeze");
	endtask

	// with no gnd pulses bn stays at the value drawn when the sweep started
	task automatic check_sweep(input int exp_pulses);
		int diff;
		int exp_mean;
		diff = en_edges - sweep_ref;
		assert (diff >= SWEEP_CYCLES - 1 && diff <= SWEEP_CYCLES + 2)
			else report_mismatch("end_flag delay", diff, SWEEP_CYCLES - 1);
		assert (rises == exp_pulses)
			else report_mismatch("trigger_gnd pulse count", rises, exp_pulses);
		for (int p = 0; p < `N_PHASES; p++) begin
			exp_mean = (exp_pulses == 0) ? int'(bn) : sums[p] / `N_REPEATS;
			assert (int'(got_means[p]) == exp_mean)
				else report_mismatch($sformatf("mean_s%0d", p + 1), int'(got_means[p]), exp_mean);
		end
	endtask

	// timeout, enabled edge count and pulse lengths in enabled cycles
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Regression failed");
			$finish;
		end else if (rst) begin
			en_edges <= 0;
			gnd_len <= 0;
			vdd_len <= 0;
		end else if (we) begin
			en_edges <= en_edges + 1;
			if (|trigger_gnd) begin
				gnd_len <= gnd_len + 1;
			end else if (gnd_len != 0) begin
				assert (gnd_len == `GND_CYCLES)
					else report_mismatch("trigger_gnd pulse length", gnd_len, `GND_CYCLES);
				gnd_len <= 0;
			end
			if (|trigger_vdd) begin
				vdd_len <= vdd_len + 1;
			end else if (vdd_len != 0) begin
				assert (vdd_len == `EXC_CYCLES)
					else report_mismatch("trigger_vdd pulse length", vdd_len, `EXC_CYCLES);
				vdd_len <= 0;
			end
		end
	end

	// divider check and reference model, new bn for every repetition
	always @(negedge clk) begin
		if (rst) begin
			prev_gnd = 1'b0;
			prev_end = 1'b0;
		end else begin
			exp_clk = ((en_edges / `ADC_CLK_HALF) % 2) == 1;
			assert (adc_clk == exp_clk)
				else report_mismatch("adc_clk", int'(adc_clk), int'(exp_clk));
			new_sweep = prev_end && !end_flag;
			gnd_rise = (|trigger_gnd) && !prev_gnd;
			if (new_sweep) begin
				for (int p = 0; p < `N_PHASES; p++)
					sums[p] = 0;
				rises = 0;
				sweep_ref = en_edges;
			end
			if (gnd_rise && rises == 0)
				sweep_ref = en_edges;
			if (new_sweep || gnd_rise) begin
				draw = $random(seed);
				bn <= draw[`SAMPLE_W-1:0];
			end
			if (gnd_rise) begin
				if (rises < SWEEP_PULSES)
					sums[rises / `N_REPEATS] += int'(draw[`SAMPLE_W-1:0]);
				rises++;
			end
			prev_gnd = |trigger_gnd;
			prev_end = end_flag;
		end
	end

	a_exclusive: assert property (@(posedge clk) disable iff (rst)
		!((|trigger_vdd) && (|trigger_gnd)))
		else report_error("trigger_vdd and trigger_gnd driven together");

	a_selected_only: assert property (@(posedge clk) disable iff (rst)
		((trigger_vdd | trigger_gnd) & ~sel_mask($past(trigger_sel))) == '0)
		else report_error("trigger output on a channel that is not selected");

	initial begin
		rst = 1'b1;
		we = 1'b0;
		one_shot = 1'b1;
		trigger_sel = 4'd2;

		repeat (8) begin
			@(negedge clk);
			check_idle_outputs();
		end
		rst = 1'b0;
		@(negedge clk);
		check_idle_outputs();
		finish_test("reset");

		we = 1'b1;
		wait_end_flag(1'b1, "end_flag did not rise after the first sweep");
		check_sweep(SWEEP_PULSES);
		finish_test("sweep_channel_2");

		// result parked in DONE
		for (int p = 0; p < `N_PHASES; p++)
			held[p] = got_means[p];
		repeat (100) begin
			@(negedge clk);
			assert (end_flag) else report_error("end_flag dropped while one_shot is high");
			assert (trigger_vdd == '0 && trigger_gnd == '0)
				else report_error("trigger driven while the result is held");
			for (int p = 0; p < `N_PHASES; p++) begin
				assert (got_means[p] == held[p])
					else report_mismatch($sformatf("mean_s%0d", p + 1),
						int'(got_means[p]), int'(held[p]));
			end
		end
		finish_test("one_shot_hold");

		one_shot = 1'b0;
		wait_end_flag(1'b0, "end_flag did not fall after one_shot dropped");
		one_shot = 1'b1;
		repeat (300) @(negedge clk);
		wait_vdd_pulse();
		repeat (5) @(negedge clk);
		frozen_clk = adc_clk;
		frozen_vdd = trigger_vdd;
		frozen_gnd = trigger_gnd;
		we = 1'b0;
		repeat (30) begin
			@(negedge clk);
			assert (adc_clk == frozen_clk)
				else report_mismatch("adc_clk", int'(adc_clk), int'(frozen_clk));
			assert (trigger_vdd == frozen_vdd)
				else report_mismatch("trigger_vdd", int'(trigger_vdd), int'(frozen_vdd));
			assert (trigger_gnd == frozen_gnd)
				else report_mismatch("trigger_gnd", int'(trigger_gnd), int'(frozen_gnd));
		end
		we = 1'b1;
		finish_test("run_enable_freeze");
		wait_end_flag(1'b1, "end_flag did not rise after the restarted sweep");
		check_sweep(SWEEP_PULSES);
		finish_test("one_shot_restart");

		// selector beyond the last channel drives nothing
		trigger_sel = 4'd5;
		one_shot = 1'b0;
		wait_end_flag(1'b0, "end_flag did not fall for the third sweep");
		one_shot = 1'b1;
		wait_end_flag(1'b1, "end_flag did not rise after the third sweep");
		check_sweep(0);
		finish_test("channel_off");

		$display("summary: %0d tests, %0d errors", test_count, err_count);
		if (err_count == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== adc_sweep.f ====
+incdir+.
adc_sweep_pkg.sv
adc_clock_div.sv
sweep_sequencer.sv
trigger_driver.sv
sample_accumulator.sv
adc_sweep_top.sv
tb_adc_sweep.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the adc_sweep testbench with Verilator, run it, judge the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f adc_sweep.f \
	--top-module tb_adc_sweep -o tb_adc_sweep --Mdir obj_dir > build.log 2>&1 &&
./obj_dir/tb_adc_sweep > sim.log 2>&1 &&
cat sim.log &&
! grep -q "Regression failed" sim.log &&
grep -q "Regression passed" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }
